//--- common/seq_init_pkg.sv
`default_nettype none

package seq_init_pkg;

    // Cluster ids are 8 bits wide and id 0 is reserved to mean no cluster
    localparam int CLUSTER_ID_WIDTH = 8;
    // Width of one sequence number as it is stored in the table
    localparam int SEQ_NUM_WIDTH = 32;

    typedef logic [CLUSTER_ID_WIDTH-1:0] cluster_id_t;
    typedef logic [SEQ_NUM_WIDTH-1:0] seq_num_t;
    typedef logic [7:0] msg_type_t;

    // Request code for asking a cluster for its current sequence number
    localparam msg_type_t MSG_SEQ_NUM_CHECK = 8'h21;

    // Request message sent to one remote cluster
    // The sender field carries our own cluster id
    typedef struct packed {
        msg_type_t   msg_type;
        cluster_id_t sender;
        cluster_id_t dest;
    } req_msg_t;

    // Reply from a remote cluster with its current sequence number
    typedef struct packed {
        cluster_id_t sender;
        seq_num_t    seq_num;
    } reply_msg_t;

    // One word write into the sequence-number table, addressed by cluster id
    typedef struct packed {
        cluster_id_t addr;
        seq_num_t    data;
    } tbl_wr_t;

    // Controller states where idle only lasts a single cycle after reset
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT,
        ST_DONE
    } init_state_e;

endpackage

`default_nettype wire

//--- verilog/init_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module init_ctrl_fsm
    import seq_init_pkg::*;
(
    input  wire  i_clk,
    input  wire  i_ap_rst_n,
    input  wire  i_round_done,
    input  wire  i_all_received,
    input  wire  i_expired,
    output logic o_sending,
    output logic o_listening,
    output logic o_load_round,
    output logic o_reply_ready,
    output logic o_done
);

    init_state_e r_state;
    init_state_e w_next_state;

    always_comb begin
        w_next_state = r_state;
        unique case (r_state)
            // Leave idle straight away so the first round starts one cycle after reset
            ST_IDLE: w_next_state = ST_SEND;
            // Stay here until the last request of the round has been accepted
            ST_SEND: begin
                if (i_round_done) begin
                    w_next_state = ST_WAIT;
                end
            end
            ST_WAIT: begin
                // Completion has priority over a timeout in the same cycle
                if (i_all_received) begin
                    w_next_state = ST_DONE;
                end else if (i_expired) begin
                    w_next_state = ST_SEND;
                end
            end
            // Terminal until the next reset
            ST_DONE: w_next_state = ST_DONE;
            default: w_next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            r_state <= ST_IDLE;
        end else begin
            r_state <= w_next_state;
        end
    end

    assign o_sending   = (r_state == ST_SEND);
    assign o_listening = (r_state == ST_WAIT);
    // Tells the scheduler to reload its target mask as we head back to SEND
    assign o_load_round = (r_state == ST_WAIT) && i_expired && !i_all_received;
    // Late replies after completion are still drained so the link never stalls
    assign o_reply_ready = (r_state == ST_WAIT) || (r_state == ST_DONE);
    assign o_done        = (r_state == ST_DONE);

    // Once every cluster has answered, done must hold until reset
    a_done_sticky : assert property (
        @(posedge i_clk) disable iff (!i_ap_rst_n) o_done |=> o_done
    );

endmodule

`default_nettype wire

//--- verilog/reply_timer.sv
`timescale 1ns/100ps
`default_nettype none

module reply_timer #(
    parameter int REPLY_TIMEOUT = 3600
) (
    input  wire  i_clk,
    input  wire  i_ap_rst_n,
    input  wire  i_run,
    output logic o_expired
);

    // The counter only has to reach REPLY_TIMEOUT-1 and keeps at least one bit
    localparam int CNT_W = (REPLY_TIMEOUT > 1) ? $clog2(REPLY_TIMEOUT) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(REPLY_TIMEOUT - 1);

    logic [CNT_W-1:0] r_count;

    // The first cycle with i_run high sees a count of zero, so the
    // REPLY_TIMEOUT-th consecutive cycle sees LAST_CNT
    assign o_expired = i_run && (r_count == LAST_CNT);

    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            r_count <= '0;
        end else if (!i_run || o_expired) begin
            // Start over when waiting stops or after each expiry
            r_count <= '0;
        end else begin
            r_count <= r_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/outstanding_tracker.sv
`timescale 1ns/100ps
`default_nettype none

module outstanding_tracker
    import seq_init_pkg::*;
#(
    parameter int NUM_CLUSTERS = 16
) (
    input  wire                     i_clk,
    input  wire                     i_ap_rst_n,
    input  wire                     i_listening,
    input  wire                     i_reply_valid,
    input  reply_msg_t              i_reply,
    output logic                    o_tbl_wr_en,
    output tbl_wr_t                 o_tbl_wr,
    output logic [NUM_CLUSTERS-1:0] o_pending_next,
    output logic                    o_all_received
);

    // Bit i set means cluster i+1 has not replied yet
    logic [NUM_CLUSTERS-1:0] r_pending;
    logic                    w_in_range;
    cluster_id_t             w_index;
    logic [NUM_CLUSTERS-1:0] w_sender_onehot;
    logic                    w_accept;

    // Id 0 and anything above the cluster count are not ours to track
    assign w_in_range = (i_reply.sender != '0) &&
                        (i_reply.sender <= cluster_id_t'(NUM_CLUSTERS));
    assign w_index    = i_reply.sender - 1'b1;
    // Out-of-range senders map to an empty mask so they never match
    assign w_sender_onehot = w_in_range ? (NUM_CLUSTERS'(1) << w_index) : '0;

    // A retransmitted reply finds its bit already cleared and is dropped here
    assign w_accept = i_listening && i_reply_valid && |(w_sender_onehot & r_pending);

    assign o_pending_next = w_accept ? (r_pending & ~w_sender_onehot) : r_pending;
    // Fires only on the reply that clears the final bit
    assign o_all_received = w_accept && (o_pending_next == '0);

    // The table is written in the same cycle the reply is consumed
    assign o_tbl_wr_en      = w_accept;
    assign o_tbl_wr.addr    = i_reply.sender;
    assign o_tbl_wr.data    = i_reply.seq_num;

    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            r_pending <= '1;
        end else begin
            r_pending <= o_pending_next;
        end
    end

    // Writes only happen while the controller is waiting for replies
    a_wr_only_listening : assert property (
        @(posedge i_clk) disable iff (!i_ap_rst_n) o_tbl_wr_en |-> i_listening
    );

endmodule

`default_nettype wire

//--- verilog/request_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

module request_scheduler
    import seq_init_pkg::*;
#(
    parameter int NUM_CLUSTERS = 16
) (
    input  wire                     i_clk,
    input  wire                     i_ap_rst_n,
    input  cluster_id_t             i_own_cluster_id,
    input  wire                     i_sending,
    input  wire                     i_load_round,
    input  wire  [NUM_CLUSTERS-1:0] i_pending_next,
    input  wire                     i_req_ready,
    output logic                    o_req_valid,
    output req_msg_t                o_req,
    output logic                    o_round_done
);

    // Clusters still to be asked in this round in the same bit order as the tracker
    logic [NUM_CLUSTERS-1:0] r_target;
    logic [NUM_CLUSTERS-1:0] w_target_rest;
    cluster_id_t             w_dest;
    logic                    w_xfer;

    // Lowest set bit picks the destination, which walks ids in ascending order
    always_comb begin
        w_dest = '0;
        for (int i = NUM_CLUSTERS - 1; i >= 0; i--) begin
            if (r_target[i]) begin
                w_dest = cluster_id_t'(i + 1);
            end
        end
    end

    // Clearing the lowest set bit leaves the rest of the round
    assign w_target_rest = r_target & (r_target - 1'b1);

    assign o_req_valid = i_sending;
    assign w_xfer      = o_req_valid && i_req_ready;
    // The round ends on the transfer that consumes the last remaining bit
    assign o_round_done = w_xfer && (w_target_rest == '0);

    assign o_req.msg_type = MSG_SEQ_NUM_CHECK;
    assign o_req.sender   = i_own_cluster_id;
    assign o_req.dest     = w_dest;

    always_ff @(posedge i_clk or negedge i_ap_rst_n) begin
        if (!i_ap_rst_n) begin
            // The first round targets every cluster
            r_target <= '1;
        end else if (i_load_round) begin
            // Resend rounds only go to clusters that are still silent
            r_target <= i_pending_next;
        end else if (w_xfer) begin
            r_target <= w_target_rest;
        end
    end

    // The FSM must never offer a request when the round mask is empty
    a_dest_in_range : assert property (
        @(posedge i_clk) disable iff (!i_ap_rst_n)
        o_req_valid |-> (o_req.dest >= 1 && o_req.dest <= NUM_CLUSTERS)
    );

endmodule

`default_nettype wire

//--- verilog/seq_num_initializer.sv
`timescale 1ns/100ps
`default_nettype none

module seq_num_initializer
    import seq_init_pkg::*;
#(
    parameter int NUM_CLUSTERS  = 16,
    parameter int REPLY_TIMEOUT = 3600
) (
    input  wire         i_clk,
    input  wire         i_ap_rst_n,
    input  cluster_id_t i_own_cluster_id,
    // Outgoing request stream
    output logic        o_req_valid,
    input  wire         i_req_ready,
    output req_msg_t    o_req,
    // Incoming reply stream
    input  wire         i_reply_valid,
    output logic        o_reply_ready,
    input  reply_msg_t  i_reply,
    // Sequence-number table write port
    output logic        o_tbl_wr_en,
    output tbl_wr_t     o_tbl_wr,
    output logic        o_done
);

    // Control handshakes between the FSM and the datapath blocks
    logic w_sending;
    logic w_listening;
    logic w_load_round;
    logic w_round_done;
    logic w_all_received;
    logic w_expired;
    // Outstanding mask as it will look after this cycle, which seeds a resend round
    logic [NUM_CLUSTERS-1:0] w_pending_next;

    init_ctrl_fsm u_ctrl_fsm (
        .i_clk          (i_clk),
        .i_ap_rst_n     (i_ap_rst_n),
        .i_round_done   (w_round_done),
        .i_all_received (w_all_received),
        .i_expired      (w_expired),
        .o_sending      (w_sending),
        .o_listening    (w_listening),
        .o_load_round   (w_load_round),
        .o_reply_ready  (o_reply_ready),
        .o_done         (o_done)
    );

    // The timer only runs while the FSM waits for replies
    reply_timer #(
        .REPLY_TIMEOUT (REPLY_TIMEOUT)
    ) u_reply_timer (
        .i_clk      (i_clk),
        .i_ap_rst_n (i_ap_rst_n),
        .i_run      (w_listening),
        .o_expired  (w_expired)
    );

    outstanding_tracker #(
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) u_tracker (
        .i_clk          (i_clk),
        .i_ap_rst_n     (i_ap_rst_n),
        .i_listening    (w_listening),
        .i_reply_valid  (i_reply_valid),
        .i_reply        (i_reply),
        .o_tbl_wr_en    (o_tbl_wr_en),
        .o_tbl_wr       (o_tbl_wr),
        .o_pending_next (w_pending_next),
        .o_all_received (w_all_received)
    );

    request_scheduler #(
        .NUM_CLUSTERS (NUM_CLUSTERS)
    ) u_scheduler (
        .i_clk            (i_clk),
        .i_ap_rst_n       (i_ap_rst_n),
        .i_own_cluster_id (i_own_cluster_id),
        .i_sending        (w_sending),
        .i_load_round     (w_load_round),
        .i_pending_next   (w_pending_next),
        .i_req_ready      (i_req_ready),
        .o_req_valid      (o_req_valid),
        .o_req            (o_req),
        .o_round_done     (w_round_done)
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset is released 1 ns after a rising edge like the rest of the stimulus
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/seq_num_initializer_tb.sv
`timescale 1ns/100ps
`default_nettype none

module seq_num_initializer_tb
    import seq_init_pkg::*;
();

    localparam int NUM_CLUSTERS  = 8;
    localparam int REPLY_TIMEOUT = 40;
    localparam int CLK_PERIOD_NS = 4;
    // Three rounds at most, each with stalled requests, a full wait and some slack
    localparam int WATCHDOG_CYCLES = 3 * (NUM_CLUSTERS * 8 + REPLY_TIMEOUT + 20);
    localparam cluster_id_t OWN_ID = 8'h0C;

    logic        clk;
    logic        rst_n;
    cluster_id_t own_cluster_id;
    logic        req_valid;
    logic        req_ready;
    req_msg_t    req;
    logic        reply_valid;
    logic        reply_ready;
    reply_msg_t  reply;
    logic        tbl_wr_en;
    tbl_wr_t     tbl_wr;
    logic        done;

    // Cluster model state
    seq_num_t    cluster_seq [1:NUM_CLUSTERS];
    int          reply_delay [1:NUM_CLUSTERS];
    int          request_seen [1:NUM_CLUSTERS];
    reply_msg_t  reply_q [$];
    logic        late_sent;
    logic        model_xfer;
    cluster_id_t model_dest;
    logic        model_taken;

    // Scoreboard state where bit i stands for cluster i
    logic [NUM_CLUSTERS:1] written_mask;
    logic [NUM_CLUSTERS:1] round_mask;
    int          written_count;
    int          request_count;
    int          error_count;
    int          expected_dest;
    int          idle_cycles;
    logic        prev_req_valid;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (8)
    ) u_clock_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    seq_num_initializer #(
        .NUM_CLUSTERS  (NUM_CLUSTERS),
        .REPLY_TIMEOUT (REPLY_TIMEOUT)
    ) uut (
        .i_clk            (clk),
        .i_ap_rst_n       (rst_n),
        .i_own_cluster_id (own_cluster_id),
        .o_req_valid      (req_valid),
        .i_req_ready      (req_ready),
        .o_req            (req),
        .i_reply_valid    (reply_valid),
        .o_reply_ready    (reply_ready),
        .i_reply          (reply),
        .o_tbl_wr_en      (tbl_wr_en),
        .o_tbl_wr         (tbl_wr),
        .o_done           (done)
    );

    // Returns the smallest cluster id still set in a round mask or 0 when it is empty
    function automatic int lowest_pending_id(input logic [NUM_CLUSTERS:1] mask);
        int id;
        id = 0;
        for (int i = NUM_CLUSTERS; i >= 1; i--) begin
            if (mask[i]) begin
                id = i;
            end
        end
        return id;
    endfunction

    task automatic queue_reply(input cluster_id_t sender, input seq_num_t seq_num);
        reply_msg_t msg;
        msg.sender  = sender;
        msg.seq_num = seq_num;
        reply_q.push_back(msg);
    endtask

    // Remote clusters sample handshakes at the falling edge and
    // drive new inputs 1 ns after the rising edge
    always begin
        @(negedge clk);
        model_xfer  = req_valid && req_ready;
        model_dest  = req.dest;
        model_taken = reply_valid && reply_ready;
        @(posedge clk);
        #1;
        if (model_taken) begin
            void'(reply_q.pop_front());
        end
        for (int id = 1; id <= NUM_CLUSTERS; id++) begin
            if (reply_delay[id] > 0) begin
                reply_delay[id]--;
                if (reply_delay[id] == 0) begin
                    queue_reply(cluster_id_t'(id), cluster_seq[id]);
                    // Cluster 1 also retransmits, and two strangers chime in
                    if (id == 1) begin
                        queue_reply(8'd1, cluster_seq[1]);
                        queue_reply(8'd0, $urandom);
                        queue_reply(8'd9, $urandom);
                    end
                end
            end
        end
        if (model_xfer && model_dest >= 1 && model_dest <= NUM_CLUSTERS) begin
            request_seen[model_dest]++;
            // The first request to clusters 3 and 6 is lost on the link
            if (!(request_seen[model_dest] == 1 && (model_dest == 3 || model_dest == 6))) begin
                reply_delay[model_dest] = 2 + ($urandom % 4);
            end
        end
        // One more reply shows up after completion and must be drained silently
        if (done && !late_sent) begin
            queue_reply(8'd2, cluster_seq[2]);
            late_sent = 1'b1;
        end
        req_ready   = ($urandom % 10) < 7;
        reply_valid = (reply_q.size() != 0);
        reply       = reply_valid ? reply_q[0] : '0;
    end

    // Scoreboard of table writes and request order
    always @(negedge clk) begin
        if (rst_n) begin
            if (tbl_wr_en && tbl_wr.addr >= 1 && tbl_wr.addr <= NUM_CLUSTERS) begin
                assert (!written_mask[tbl_wr.addr]) else begin
                    error_count++;
                    $display("Table address %0d was written a second time", tbl_wr.addr);
                end
                if (!written_mask[tbl_wr.addr]) begin
                    written_count++;
                    written_mask[tbl_wr.addr] = 1'b1;
                end
            end
            // A new round goes to every cluster whose table entry is still missing
            if (req_valid && !prev_req_valid) begin
                // A resend round follows a full reply timeout without any request
                if (request_count != 0) begin
                    assert (idle_cycles == REPLY_TIMEOUT) else begin
                        error_count++;
                        $display("FAILED idle_cycles before resend got %h expected %h",
                                 idle_cycles, REPLY_TIMEOUT);
                    end
                end
                round_mask = ~written_mask;
            end
            if (req_valid && req_ready) begin
                expected_dest = lowest_pending_id(round_mask);
                assert (req.dest == expected_dest) else begin
                    error_count++;
                    $display("FAILED o_req.dest got %h expected %h", req.dest, expected_dest);
                end
                if (expected_dest != 0) begin
                    round_mask[expected_dest] = 1'b0;
                end
                request_count++;
            end
            if (!req_valid && prev_req_valid) begin
                assert (round_mask == '0) else begin
                    error_count++;
                    $display("A request round ended before every target was asked");
                end
            end
            prev_req_valid = req_valid;
            idle_cycles    = req_valid ? 0 : idle_cycles + 1;
        end
    end

    a_reset_quiet : assert property (@(posedge clk)
        (!rst_n || $rose(rst_n)) |-> (!req_valid && !reply_ready && !tbl_wr_en && !done)
    ) else begin
        error_count++;
        $display("Outputs were active during reset or the idle cycle after it");
    end

    // Past the idle cycle the reply side is open exactly when no request is offered
    a_reply_ready : assert property (@(posedge clk) disable iff (!rst_n)
        !$rose(rst_n) |-> (reply_ready == !req_valid)
    ) else begin
        error_count++;
        $display("FAILED o_reply_ready got %h expected %h",
                 $sampled(reply_ready), !$sampled(req_valid));
    end

    a_req_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid && !req_ready) |=> (req_valid && $stable(req))
    ) else begin
        error_count++;
        $display("The request changed or dropped while the sink was stalling");
    end

    a_req_type : assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (req.msg_type == MSG_SEQ_NUM_CHECK)
    ) else begin
        error_count++;
        $display("FAILED o_req.msg_type got %h expected %h",
                 $sampled(req.msg_type), MSG_SEQ_NUM_CHECK);
    end

    a_req_sender : assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (req.sender == own_cluster_id)
    ) else begin
        error_count++;
        $display("FAILED o_req.sender got %h expected %h", $sampled(req.sender), OWN_ID);
    end

    a_wr_addr : assert property (@(posedge clk) disable iff (!rst_n)
        tbl_wr_en |-> (tbl_wr.addr >= 1 && tbl_wr.addr <= NUM_CLUSTERS)
    ) else begin
        error_count++;
        $display("FAILED o_tbl_wr.addr got %h expected 01..%h", $sampled(tbl_wr.addr),
                 NUM_CLUSTERS);
    end

    a_wr_data : assert property (@(posedge clk) disable iff (!rst_n)
        (tbl_wr_en && tbl_wr.addr >= 1 && tbl_wr.addr <= NUM_CLUSTERS)
            |-> (tbl_wr.data == cluster_seq[tbl_wr.addr])
    ) else begin
        error_count++;
        $display("FAILED o_tbl_wr.data got %h expected %h", $sampled(tbl_wr.data),
                 cluster_seq[$sampled(tbl_wr.addr)]);
    end

    a_no_write_after_done : assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !tbl_wr_en
    ) else begin
        error_count++;
        $display("A reply consumed after completion still wrote the table");
    end

    a_done_after_all : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> (written_count == NUM_CLUSTERS)
    ) else begin
        error_count++;
        $display("FAILED written_count got %h expected %h at o_done",
                 $sampled(written_count), NUM_CLUSTERS);
    end

    a_done_sticky : assert property (@(posedge clk) disable iff (!rst_n)
        done |=> done
    ) else begin
        error_count++;
        $display("o_done fell after it had been raised");
    end

    a_quiet_after_done : assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !req_valid
    ) else begin
        error_count++;
        $display("A request was offered after completion");
    end

    initial begin
        void'($urandom(63519));
        own_cluster_id = OWN_ID;
        req_ready      = 1'b0;
        reply_valid    = 1'b0;
        reply          = '0;
        late_sent      = 1'b0;
        written_mask   = '0;
        round_mask     = '0;
        written_count  = 0;
        request_count  = 0;
        error_count    = 0;
        idle_cycles    = 0;
        prev_req_valid = 1'b0;
        for (int id = 1; id <= NUM_CLUSTERS; id++) begin
            cluster_seq[id]  = $urandom;
            reply_delay[id]  = 0;
            request_seen[id] = 0;
        end
        wait (rst_n);
        while (!done) begin
            @(negedge clk);
        end
        // Give the late reply time to be drained in the done state
        repeat (20) @(negedge clk);
        if (written_count != NUM_CLUSTERS) begin
            error_count++;
            $display("FAILED written_count got %h expected %h", written_count, NUM_CLUSTERS);
        end
        // One full round plus the resend to clusters 3 and 6
        if (request_count != NUM_CLUSTERS + 2) begin
            error_count++;
            $display("FAILED request_count got %h expected %h", request_count,
                     NUM_CLUSTERS + 2);
        end
        $display("Run finished with %0d errors after %0d requests and %0d table writes",
                 error_count, request_count, written_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("Watchdog ran out after %0d cycles with %0d errors counted",
                 WATCHDOG_CYCLES, error_count);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- seq_num_initializer.f
common/seq_init_pkg.sv
verilog/init_ctrl_fsm.sv
verilog/reply_timer.sv
verilog/outstanding_tracker.sv
verilog/request_scheduler.sv
verilog/seq_num_initializer.sv
test/tb_clock_gen.sv
test/seq_num_initializer_tb.sv

//--- Bender.yml
package:
  name: seq_num_initializer

sources:
  - common/seq_init_pkg.sv
  - verilog/init_ctrl_fsm.sv
  - verilog/reply_timer.sv
  - verilog/outstanding_tracker.sv
  - verilog/request_scheduler.sv
  - verilog/seq_num_initializer.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/seq_num_initializer_tb.sv
